// File: common/fm_tile_pkg.sv
// tile geometry defaults; TM must be a multiple of X_BANKS and the top level may override all four
`default_nettype none

package fm_tile_pkg;

    // default tile shape
    parameter int TM      = 8;  // channels per tile
    parameter int TR      = 4;  // rows per channel
    parameter int TC      = 4;  // columns per channel
    parameter int X_BANKS = 4;  // channel c lives in bank c mod X_BANKS

    // width of a counter or address for n distinct values, never below 1
    function automatic int addr_w(input int n);
        int w;
        w = (n > 1) ? $clog2(n) : 1;
        return w;
    endfunction

    // words one bank has to hold for a full tile
    function automatic int bank_words(
        input int tm,
        input int tr,
        input int tc,
        input int xb
    );
        int w;
        w = (tm / xb) * tr * tc;
        return w;
    endfunction

    // derived from the defaults
    parameter int BANK_WORDS = bank_words(TM, TR, TC, X_BANKS);
    parameter int BANK_AW    = addr_w(BANK_WORDS);
    parameter int CH_W       = addr_w(TM);  // width of a channel number

endpackage

`default_nettype wire

// File: common/fm_bus_pkg.sv
// bus and stream widths; the whole datapath carries one fixed 32-bit word
`default_nettype none

package fm_bus_pkg;

    // data word on wishbone, in the banks and on the stream
    parameter int DW = 32;

    typedef logic [DW-1:0] word_t;

    // wishbone address width
    // loading is strictly sequential so the address
    // is taken on the bus but never decoded
    parameter int WB_AW = 8;

endpackage

`default_nettype wire

// File: input_fm/input_fm_loader.sv
// wishbone classic write-only slave; address and byte selects ignored, one idle cycle between words
`timescale 1ns/1ps
`default_nettype none

module input_fm_loader #(
    parameter int TM      = fm_tile_pkg::TM,
    parameter int TR      = fm_tile_pkg::TR,
    parameter int TC      = fm_tile_pkg::TC,
    parameter int X_BANKS = fm_tile_pkg::X_BANKS
) (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    // wishbone classic slave
    input  wire logic                           wb_cyc,
    input  wire logic                           wb_stb,
    input  wire logic                           wb_we,
    input  wire logic [fm_bus_pkg::WB_AW-1:0]   wb_adr,   // not decoded, loading is sequential
    input  wire fm_bus_pkg::word_t              wb_dat_w,
    output logic                                wb_ack,
    output logic                                wb_err,
    // tile control
    input  wire logic                           tile_release,
    output logic                                tile_loaded,
    // to the banks
    output logic [X_BANKS-1:0]                  bank_wr_en,
    output fm_bus_pkg::word_t                   bank_wr_data
);

    localparam int WPC   = TR * TC;                      // words per channel
    localparam int WC_W  = fm_tile_pkg::addr_w(WPC);
    localparam int CHC_W = fm_tile_pkg::addr_w(TM);

    logic             req;          // new request, not the one already answered
    logic             accept;       // write that gets stored
    logic             full;         // last word taken, refuse the rest
    logic [WC_W-1:0]  word_cnt;     // position in current channel
    logic [CHC_W-1:0] ch_cnt;       // current channel
    logic             last_word;
    logic [X_BANKS-1:0] bank_sel;   // one-hot strobe for ch_cnt mod X_BANKS

    // the request stays up during the ack cycle, so mask it there
    assign req       = wb_cyc & wb_stb & ~wb_ack & ~wb_err;
    assign accept    = req & wb_we & ~full & ~tile_release;
    assign last_word = (word_cnt == WC_W'(WPC - 1));

    always_comb begin
        bank_sel = '0;
        bank_sel[ch_cnt % X_BANKS] = 1'b1;
    end

    // ack/err, strobes and counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack      <= 1'b0;
            wb_err      <= 1'b0;
            bank_wr_en  <= '0;
            word_cnt    <= '0;
            ch_cnt      <= '0;
            full        <= 1'b0;
            tile_loaded <= 1'b0;
        end else begin
            wb_ack     <= accept;
            wb_err     <= req & ~accept;                 // reads, overflow, write during release
            bank_wr_en <= accept ? bank_sel : '0;
            tile_loaded <= full;                         // one cycle after the final ack
            if (tile_release) begin
                word_cnt    <= '0;
                ch_cnt      <= '0;
                full        <= 1'b0;
                tile_loaded <= 1'b0;
            end else if (accept) begin
                if (last_word) begin
                    word_cnt <= '0;
                    ch_cnt   <= ch_cnt + 1'b1;
                    if (ch_cnt == CHC_W'(TM - 1)) begin
                        full   <= 1'b1;                  // tile complete
                        ch_cnt <= '0;
                    end
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    // payload, shared by all banks
    always_ff @(posedge clk) begin
        if (accept) begin
            bank_wr_data <= wb_dat_w;
        end
    end

endmodule

`default_nettype wire

// File: input_fm/input_fm_bank.sv
// one bank; writes must arrive strictly in order, read data comes two clocks after the address
`timescale 1ns/1ps
`default_nettype none

module input_fm_bank #(
    parameter int TM      = fm_tile_pkg::TM,
    parameter int TR      = fm_tile_pkg::TR,
    parameter int TC      = fm_tile_pkg::TC,
    parameter int X_BANKS = fm_tile_pkg::X_BANKS,
    localparam int BANK_WORDS = fm_tile_pkg::bank_words(TM, TR, TC, X_BANKS),
    localparam int BANK_AW    = fm_tile_pkg::addr_w(BANK_WORDS)
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                wr_en,
    input  wire fm_bus_pkg::word_t   wr_data,
    input  wire logic                tile_release,   // rewinds the write address
    input  wire logic [BANK_AW-1:0]  rd_addr,
    output fm_bus_pkg::word_t        rd_data
);

    logic               wr_en_q;
    fm_bus_pkg::word_t  wr_data_q;
    logic [BANK_AW-1:0] wr_addr;      // next free slot
    logic [BANK_AW-1:0] rd_addr_q;

    fm_bus_pkg::word_t  mem [BANK_WORDS];

    // write strobe and address counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_en_q <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr_en_q <= wr_en;
            if (tile_release) begin
                wr_addr <= '0;
            end else if (wr_en_q) begin
                // wrap keeps the counter in range
                wr_addr <= (wr_addr == BANK_AW'(BANK_WORDS - 1)) ? '0 : wr_addr + 1'b1;
            end
        end
    end

    // memory with registered read address and registered output
    // same-address read and write in one cycle returns old data
    always_ff @(posedge clk) begin
        wr_data_q <= wr_data;
        rd_addr_q <= rd_addr;
        rd_data   <= mem[rd_addr_q];
        if (wr_en_q) begin
            mem[wr_addr] <= wr_data_q;
        end
    end

endmodule

`default_nettype wire

// File: input_fm/input_fm_reader.sv
// streams one channel of a loaded tile; the host must hold out_ready legal per valid/ready rules
`timescale 1ns/1ps
`default_nettype none

module input_fm_reader #(
    parameter int TM      = fm_tile_pkg::TM,
    parameter int TR      = fm_tile_pkg::TR,
    parameter int TC      = fm_tile_pkg::TC,
    parameter int X_BANKS = fm_tile_pkg::X_BANKS,
    localparam int BANK_AW = fm_tile_pkg::addr_w(fm_tile_pkg::bank_words(TM, TR, TC, X_BANKS)),
    localparam int CH_W    = fm_tile_pkg::addr_w(TM)
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                tile_loaded,
    // command
    input  wire logic                rd_start,
    input  wire logic [CH_W-1:0]     rd_ch,
    output logic                     rd_busy,
    // bank side
    output logic [BANK_AW-1:0]       bank_rd_addr,   // shared by all banks
    input  wire fm_bus_pkg::word_t   bank_rd_data [X_BANKS],
    // stream out
    output logic                     out_valid,
    output fm_bus_pkg::word_t        out_data,
    input  wire logic                out_ready
);

    localparam int N     = TR * TC;                       // words per channel
    localparam int CNT_W = fm_tile_pkg::addr_w(N + 1);
    localparam int SEL_W = fm_tile_pkg::addr_w(X_BANKS);

    logic               start_ok;
    logic [SEL_W-1:0]   sel_q;       // latched bank
    logic [BANK_AW-1:0] base_q;      // channel start inside that bank
    logic [CNT_W-1:0]   iss_cnt;     // addresses issued
    logic [CNT_W-1:0]   out_cnt;     // words handed over
    logic               issue;
    logic               v1;          // address taken by the bank
    logic               v2;          // bank data valid now
    logic [2:0]         occ;         // in flight plus buffered, after this cycle's handshake
    fm_bus_pkg::word_t  rd_word;
    fm_bus_pkg::word_t  buf_q [2];   // skid buffer
    logic               wr_ptr;
    logic               rd_ptr;
    logic [1:0]         fifo_cnt;
    logic               fifo_empty;
    logic               push;
    logic               pop;
    logic               hs;

    assign start_ok = rd_start & ~rd_busy & tile_loaded;   // ignored otherwise

    assign rd_word    = bank_rd_data[sel_q];
    assign fifo_empty = (fifo_cnt == 2'd0);

    // empty buffer passes bank data straight through
    assign out_valid = ~fifo_empty | v2;
    assign out_data  = fifo_empty ? rd_word : buf_q[rd_ptr];
    assign hs        = out_valid & out_ready;
    assign pop       = ~fifo_empty & out_ready;
    assign push      = v2 & ~(fifo_empty & out_ready);   // v2 word not taken directly

    // throttle so nothing issued can overflow the 2-entry buffer
    assign occ   = 3'(v1) + 3'(v2) + 3'(fifo_cnt) - 3'(hs);
    assign issue = rd_busy & (iss_cnt != CNT_W'(N)) & (occ <= 3'd1);

    assign bank_rd_addr = base_q + BANK_AW'(iss_cnt);

    // sequencer and pipeline control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_busy  <= 1'b0;
            sel_q    <= '0;
            base_q   <= '0;
            iss_cnt  <= '0;
            out_cnt  <= '0;
            v1       <= 1'b0;
            v2       <= 1'b0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            fifo_cnt <= 2'd0;
        end else begin
            v1       <= issue;
            v2       <= v1;
            fifo_cnt <= fifo_cnt + 2'(push) - 2'(pop);
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            if (start_ok) begin
                rd_busy <= 1'b1;
                sel_q   <= SEL_W'(rd_ch % X_BANKS);
                base_q  <= BANK_AW'((rd_ch / X_BANKS) * N);
                iss_cnt <= '0;
                out_cnt <= '0;
            end else begin
                if (issue) iss_cnt <= iss_cnt + 1'b1;
                if (hs) begin
                    out_cnt <= out_cnt + 1'b1;
                    if (out_cnt == CNT_W'(N - 1)) begin
                        rd_busy <= 1'b0;                 // last word gone
                    end
                end
            end
        end
    end

    // buffer storage
    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr] <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: rtl/input_fm_buffer_top.sv
// input feature map buffer; one tile at a time, TM a multiple of X_BANKS, writes only on wishbone
`timescale 1ns/1ps
`default_nettype none

module input_fm_buffer_top #(
    parameter int TM      = fm_tile_pkg::TM,
    parameter int TR      = fm_tile_pkg::TR,
    parameter int TC      = fm_tile_pkg::TC,
    parameter int X_BANKS = fm_tile_pkg::X_BANKS,
    localparam int BANK_AW = fm_tile_pkg::addr_w(fm_tile_pkg::bank_words(TM, TR, TC, X_BANKS)),
    localparam int CH_W    = fm_tile_pkg::addr_w(TM)
) (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    // wishbone from host
    input  wire logic                          wb_cyc,
    input  wire logic                          wb_stb,
    input  wire logic                          wb_we,
    input  wire logic [fm_bus_pkg::WB_AW-1:0]  wb_adr,
    input  wire fm_bus_pkg::word_t             wb_dat_w,
    output logic                               wb_ack,
    output logic                               wb_err,
    // tile state
    input  wire logic                          tile_release,
    output logic                               tile_loaded,
    // read command
    input  wire logic                          rd_start,
    input  wire logic [CH_W-1:0]               rd_ch,
    output logic                               rd_busy,
    // stream out
    output logic                               out_valid,
    output fm_bus_pkg::word_t                  out_data,
    input  wire logic                          out_ready
);

    logic [X_BANKS-1:0] bank_wr_en;
    fm_bus_pkg::word_t  bank_wr_data;
    logic [BANK_AW-1:0] bank_rd_addr;
    fm_bus_pkg::word_t  bank_rd_data [X_BANKS];

    input_fm_loader #(
        .TM(TM), .TR(TR), .TC(TC), .X_BANKS(X_BANKS)
    ) u_loader (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .wb_err       (wb_err),
        .tile_release (tile_release),
        .tile_loaded  (tile_loaded),
        .bank_wr_en   (bank_wr_en),
        .bank_wr_data (bank_wr_data)
    );

    // one bank per strobe bit, all share data and read address
    for (genvar k = 0; k < X_BANKS; k++) begin : g_bank
        input_fm_bank #(
            .TM(TM), .TR(TR), .TC(TC), .X_BANKS(X_BANKS)
        ) u_bank (
            .clk          (clk),
            .arst_n       (arst_n),
            .wr_en        (bank_wr_en[k]),
            .wr_data      (bank_wr_data),
            .tile_release (tile_release),
            .rd_addr      (bank_rd_addr),
            .rd_data      (bank_rd_data[k])
        );
    end

    input_fm_reader #(
        .TM(TM), .TR(TR), .TC(TC), .X_BANKS(X_BANKS)
    ) u_reader (
        .clk          (clk),
        .arst_n       (arst_n),
        .tile_loaded  (tile_loaded),
        .rd_start     (rd_start),
        .rd_ch        (rd_ch),
        .rd_busy      (rd_busy),
        .bank_rd_addr (bank_rd_addr),
        .bank_rd_data (bank_rd_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

// File: verif/input_fm_tb_asserts.sv
// protocol checks on the buffer top level ports; all disabled while arst_n is low
`timescale 1ns/1ps
`default_nettype none

module input_fm_tb_asserts (
    input wire logic              clk,
    input wire logic              arst_n,
    input wire logic              wb_cyc,
    input wire logic              wb_stb,
    input wire logic              wb_ack,
    input wire logic              wb_err,
    input wire logic              out_valid,
    input wire fm_bus_pkg::word_t out_data,
    input wire logic              out_ready
);

    // one reply kind at a time
    ack_err_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(wb_ack && wb_err))
        else $error("wb_ack and wb_err high in the same cycle");

    // reply only for a request seen one clock earlier
    reply_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_ack || wb_err) |-> $past(wb_cyc && wb_stb))
        else $error("wishbone reply without a request the cycle before");

    // single-cycle reply
    reply_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_ack || wb_err) |=> !(wb_ack || wb_err))
        else $error("wishbone reply held longer than one cycle");

    // stalled word stays put
    out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("stream word dropped or changed while stalled");

endmodule

bind input_fm_buffer_top input_fm_tb_asserts u_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .wb_err    (wb_err),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
);

`default_nettype wire

// File: verif/input_fm_tb.sv
// directed testbench for the feature map buffer at its default tile geometry only
`timescale 1ns/1ps
`default_nettype none

module input_fm_tb;

    localparam int TM       = fm_tile_pkg::TM;
    localparam int TR       = fm_tile_pkg::TR;
    localparam int TC       = fm_tile_pkg::TC;
    localparam int CH_W     = fm_tile_pkg::CH_W;
    localparam int N        = TR * TC;      // words per channel
    localparam int WORD_TMO = 50;           // cycles allowed per reply or word

    logic                         clk;
    logic                         arst_n;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [fm_bus_pkg::WB_AW-1:0] wb_adr;
    fm_bus_pkg::word_t            wb_dat_w;
    logic                         wb_ack;
    logic                         wb_err;
    logic                         tile_release;
    logic                         tile_loaded;
    logic                         rd_start;
    logic [CH_W-1:0]              rd_ch;
    logic                         rd_busy;
    logic                         out_valid;
    fm_bus_pkg::word_t            out_data;
    logic                         out_ready;

    fm_bus_pkg::word_t model [TM][TR][TC];  // expected tile by channel then row then column
    integer            seed;
    logic [fm_bus_pkg::WB_AW-1:0] adr_next;  // wishbone address that the DUT never decodes

    input_fm_buffer_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .wb_err       (wb_err),
        .tile_release (tile_release),
        .tile_loaded  (tile_loaded),
        .rd_start     (rd_start),
        .rd_ch        (rd_ch),
        .rd_busy      (rd_busy),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_ready    (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input fm_bus_pkg::word_t exp,
                              input fm_bus_pkg::word_t act);
        if (act !== exp)
            abort_run($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Fail at %0t: %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act));
    endtask

    // one classic cycle with stb dropped where the reply is seen
    task automatic wb_write(input fm_bus_pkg::word_t data, input logic we,
                            output logic got_ack, output logic got_err);
        int waited;
        waited  = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr_next;
        wb_dat_w = data;
        adr_next = adr_next + 1'b1;
        while (!got_ack && !got_err) begin
            @(negedge clk);
            waited++;
            got_ack = wb_ack;
            got_err = wb_err;
            if (!got_ack && !got_err && waited > WORD_TMO)
                abort_run("no wishbone ack or err came back within the timeout");
        end
        check_count("wishbone reply latency", 1, waited);  // reply on the next clock
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // fills the model with fresh random words and writes them channel by channel
    task automatic load_tile();
        logic ack;
        logic err;
        int   c;
        int   r;
        int   k;
        for (c = 0; c < TM; c++) begin
            for (r = 0; r < TR; r++) begin
                for (k = 0; k < TC; k++) begin
                    check_bit("tile_loaded", 1'b0, tile_loaded);  // not full yet
                    model[c][r][k] = $random(seed);
                    wb_write(model[c][r][k], 1'b1, ack, err);
                    check_bit("wb_ack", 1'b1, ack);
                    check_bit("wb_err", 1'b0, err);
                end
            end
        end
        check_bit("tile_loaded", 1'b0, tile_loaded);  // still the final ack cycle
        @(negedge clk);
        check_bit("tile_loaded", 1'b1, tile_loaded);
    endtask

    // streams one channel with ready held high or random
    task automatic read_channel(input int ch, input bit rand_ready);
        int                got;
        int                idle;
        int                extra;
        int                rnd;
        fm_bus_pkg::word_t exp;
        @(negedge clk);
        rd_ch    = CH_W'(ch);
        rd_start = 1'b1;
        @(negedge clk);
        rd_start = 1'b0;
        check_bit("rd_busy", 1'b1, rd_busy);
        got  = 0;
        idle = 0;
        while (got < N) begin
            if (rand_ready) begin
                rnd       = $random(seed);
                out_ready = rnd[0];
            end else begin
                out_ready = 1'b1;
            end
            if (out_valid && out_ready) begin     // word passes on the coming edge
                exp = model[ch][got / TC][got % TC];
                check_word($sformatf("out_data ch %0d word %0d", ch, got), exp, out_data);
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WORD_TMO)
                    abort_run($sformatf("channel %0d stalled after %0d words", ch, got));
            end
            @(negedge clk);
        end
        out_ready = 1'b1;  // catch any word beyond the last
        idle      = 0;
        while (rd_busy) begin
            idle++;
            if (idle > WORD_TMO)
                abort_run($sformatf("rd_busy stayed high after channel %0d", ch));
            @(negedge clk);
        end
        extra = 0;
        repeat (3) begin
            if (out_valid) extra++;
            @(negedge clk);
        end
        check_count("words received", N, got + extra);
        out_ready = 1'b0;
    endtask

    task automatic test_reset_state();
        check_bit("wb_ack", 1'b0, wb_ack);
        check_bit("wb_err", 1'b0, wb_err);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("rd_busy", 1'b0, rd_busy);
        check_bit("tile_loaded", 1'b0, tile_loaded);
        // start with nothing loaded is ignored
        rd_ch     = CH_W'(2);
        rd_start  = 1'b1;
        out_ready = 1'b1;
        @(negedge clk);
        rd_start = 1'b0;
        repeat (20) begin
            check_bit("out_valid", 1'b0, out_valid);
            check_bit("rd_busy", 1'b0, rd_busy);
            @(negedge clk);
        end
        out_ready = 1'b0;
    endtask

    task automatic test_read_all();
        int c;
        for (c = 0; c < TM; c++) read_channel(c, 1'b0);
    endtask

    task automatic test_backpressure();
        read_channel(1, 1'b1);
        read_channel(6, 1'b1);
    endtask

    // overflow and read both refused and the tile left untouched
    task automatic test_overflow_write();
        logic ack;
        logic err;
        wb_write($random(seed), 1'b1, ack, err);
        check_bit("wb_ack on overflow", 1'b0, ack);
        check_bit("wb_err on overflow", 1'b1, err);
        wb_write(32'h0, 1'b0, ack, err);
        check_bit("wb_ack on read", 1'b0, ack);
        check_bit("wb_err on read", 1'b1, err);
        check_bit("tile_loaded", 1'b1, tile_loaded);
        read_channel(0, 1'b0);
    endtask

    task automatic test_release_reload();
        @(negedge clk);
        tile_release = 1'b1;
        @(negedge clk);
        tile_release = 1'b0;
        check_bit("tile_loaded after release", 1'b0, tile_loaded);
        load_tile();
        read_channel(3, 1'b0);
        read_channel(4, 1'b1);
    endtask

    // hard limit on the whole run
    initial begin
        #200_000;
        abort_run("simulation ran past its time limit");
    end

    initial begin
        seed         = 32'hae21;
        adr_next     = '0;
        arst_n       = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        tile_release = 1'b0;
        rd_start     = 1'b0;
        rd_ch        = '0;
        out_ready    = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        load_tile();
        test_read_all();
        test_backpressure();
        test_overflow_write();
        test_release_reload();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
common/fm_tile_pkg.sv
common/fm_bus_pkg.sv
input_fm/input_fm_loader.sv
input_fm/input_fm_bank.sv
input_fm/input_fm_reader.sv
rtl/input_fm_buffer_top.sv
verif/input_fm_tb_asserts.sv
verif/input_fm_tb.sv

// File: Bender.yml
package:
  name: input_fm_buffer

sources:
  # packages first, then the blocks, then the top level
  - files:
      - common/fm_tile_pkg.sv
      - common/fm_bus_pkg.sv
      - input_fm/input_fm_loader.sv
      - input_fm/input_fm_bank.sv
      - input_fm/input_fm_reader.sv
      - rtl/input_fm_buffer_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - verif/input_fm_tb_asserts.sv
      - verif/input_fm_tb.sv
